/* program.hex */
// one 64-bit ram word per line, low half is the instruction at the word address
// high half is the instruction at word address + 4, @ lines give the word index
@0
// addi x6, x0, 90 / sd x6, 8(x10)
0065342305a00313
// mret / unused
0000000030200073
// main loop at byte address 0x100
@20
// lui x10, 0x2 / ld x5, 0(x10)
0005328300002537
// addi x5, x5, 3 / sd x5, 8(x10)
0055342300328293
// jal x0, -12 back to the ld / unused
00000000ff5ff06f

/* all.f */
+incdir+logic
logic/rv_pkg.sv
logic/rv_execute.sv
logic/rv_fetch.sv
logic/rv_lsu.sv
logic/rv_bus_interconnect.sv
logic/rv_ram.sv
logic/rv_io.sv
logic/rv_system.sv
verification/rv_checker.sv
verification/tb_rv_system.sv

/* Makefile */
TOP = tb_rv_system

.PHONY: all run lint clean

all: run

run:
	verilator --binary --timing -j 0 -f all.f --top-module $(TOP) -o sim_rv
	obj_dir/sim_rv | tee sim.log
	grep -q "Finished with no errors" sim.log

lint:
	verilator --lint-only --timing -f all.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

/* verification/tb_rv_system.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_rv_system import rv_pkg::*; ();

    // every key value is held for one phase
    localparam int phase_cycles = 64;
    // reset key, eight tracking keys, one key for the interrupt tests
    localparam int key_phases = 10;
    localparam int cycle_limit = key_phases * phase_cycles + 200;

    logic       clk;
    logic       reset;
    xlen_t      key_code;
    logic       irq;
    logic       irq_ack;
    logic       art_valid;
    xlen_t      art_data;

    // checker control and status
    logic [2:0] test_id;
    logic       run_done;
    int         error_count;
    logic       report_done;

    int         cycles = 0;

    rv_system u_dut (
        .clk       (clk),
        .reset     (reset),
        .key_code  (key_code),
        .irq       (irq),
        .irq_ack   (irq_ack),
        .art_valid (art_valid),
        .art_data  (art_data)
    );

    rv_checker u_checker (
        .clk         (clk),
        .reset       (reset),
        .test_id     (test_id),
        .run_done    (run_done),
        .key_code    (key_code),
        .irq_ack     (irq_ack),
        .art_valid   (art_valid),
        .art_data    (art_data),
        .error_count (error_count),
        .report_done (report_done)
    );

    // 4 ns period
    initial clk = 1'b0;
    always #2 clk = ~clk;

    // 64-bit key from two draws
    function automatic xlen_t random_key();
        return {$urandom(), $urandom()};
    endfunction

    // counts art pulses, sampled on the rising edge
    task automatic wait_art_writes(input int count);
        int seen;
        seen = 0;
        while (seen < count) begin
            @(posedge clk);
            if (art_valid) begin
                seen++;
            end
        end
    endtask

    // irq stays high until the ack shows, dropped on the next edge
    task automatic raise_irq_until_ack();
        irq <= 1'b1;
        @(posedge clk);
        while (!irq_ack) begin
            @(posedge clk);
        end
        irq <= 1'b0;
    endtask

    // run limit
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("timeout: run did not finish within %0d cycles", cycle_limit);
            $display("Finished with errors");
            $finish;
        end
    end

    initial begin
        void'($urandom(64243));
        reset      = 1'b0;
        irq        = 1'b0;
        test_id    = 3'd1;
        run_done   = 1'b0;
        key_code   = random_key();

        // 3 cycles in reset, key held from here into the first write
        repeat (3) @(posedge clk);
        reset <= 1'b1;
        wait_art_writes(1);

        // key tracking, one new key per phase
        test_id <= 3'd2;
        for (int i = 0; i < 8; i++) begin
            key_code <= random_key();
            repeat (phase_cycles) @(posedge clk);
        end

        // interrupt entry, key fixed from here on
        test_id  <= 3'd3;
        key_code <= random_key();
        // let the loop pick up the new key first
        repeat (40) @(posedge clk);
        raise_irq_until_ack();
        wait_art_writes(1);

        // back in the loop after mret
        test_id <= 3'd4;
        wait_art_writes(2);

        // second irq while the handler still runs
        test_id <= 3'd5;
        raise_irq_until_ack();
        repeat (3) @(posedge clk);
        raise_irq_until_ack();
        wait_art_writes(1);

        run_done <= 1'b1;
        @(posedge clk);
        while (!report_done) begin
            @(posedge clk);
        end
        if (error_count == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verification/rv_checker.sv */
`timescale 1ns/1ns
`default_nettype none

module rv_checker import rv_pkg::*; (
    input  wire        clk,
    input  wire        reset,
    input  wire [2:0]  test_id,
    input  wire        run_done,
    input  wire xlen_t key_code,
    input  wire        irq_ack,
    input  wire        art_valid,
    input  wire xlen_t art_data,
    output int         error_count,
    output logic       report_done
);

    // test bookkeeping
    logic [2:0] cur_test;
    int         test_errors;
    int         tests_run;
    int         tests_failed;

    // events seen in the current test
    int acks;
    int handler_writes;

    // key history for the loop writes
    xlen_t cur_key;
    xlen_t prev_key;
    int    writes_since_change;
    logic  handler_pending;
    logic  phase_active;
    logic  phase_matched;

    initial begin
        error_count         = 0;
        report_done         = 1'b0;
        cur_test            = 3'd1;
        test_errors         = 0;
        tests_run           = 0;
        tests_failed        = 0;
        acks                = 0;
        handler_writes      = 0;
        cur_key             = '0;
        prev_key            = '0;
        writes_since_change = 1;
        handler_pending     = 1'b0;
        phase_active        = 1'b0;
        phase_matched       = 1'b0;
    end

    // loop writes key + 3, the handler writes 90
    function automatic xlen_t expected_art(input xlen_t key, input logic handler_write);
        if (handler_write) begin
            return 64'd90;
        end
        return key + 64'd3;
    endfunction

    function automatic string test_name(input logic [2:0] id);
        case (id)
            3'd1:    return "reset_quiet";
            3'd2:    return "key_tracking";
            3'd3:    return "irq_entry";
            3'd4:    return "resume_after_mret";
            3'd5:    return "masking_in_handler";
            default: return "unknown";
        endcase
    endfunction

    task automatic count_error();
        error_count++;
        test_errors++;
    endtask

    task automatic report_mismatch(input string what, input xlen_t exp, input xlen_t act);
        $display("[ERROR] %s %s: expected 0x%016h actual 0x%016h",
                 test_name(cur_test), what, exp, act);
        count_error();
    endtask

    task automatic compare_count(input string what, input int exp, input int act);
        if (act != exp) begin
            $display("[ERROR] %s %s: expected %0d actual %0d",
                     test_name(cur_test), what, exp, act);
            count_error();
        end
    endtask

    task automatic report_failure(input string msg);
        $display("%s failed: %s", test_name(cur_test), msg);
        count_error();
    endtask

    // one key phase of the tracking test ends
    task automatic close_phase();
        if (phase_active && !phase_matched) begin
            report_failure("no art write in a key phase matched the current key plus 3");
        end
        phase_active = 1'b0;
    endtask

    task automatic check_art_write();
        xlen_t exp;
        logic  stale_ok;
        if (handler_pending) begin
            exp = expected_art(cur_key, 1'b1);
            if (art_data !== exp) begin
                report_mismatch("handler write", exp, art_data);
            end
            handler_pending = 1'b0;
            handler_writes++;
        end else begin
            exp = expected_art(cur_key, 1'b0);
            // key read just before a change
            stale_ok = (writes_since_change == 0) &&
                       (art_data === expected_art(prev_key, 1'b0));
            if (art_data === exp) begin
                phase_matched = 1'b1;
            end else if (!stale_ok) begin
                report_mismatch("loop write", exp, art_data);
            end
            writes_since_change++;
        end
    endtask

    // end checks per test, then the result line
    task automatic close_test();
        close_phase();
        case (cur_test)
            3'd1: begin
                compare_count("acknowledges", 0, acks);
            end
            3'd2: begin
                compare_count("acknowledges", 0, acks);
                compare_count("handler writes", 0, handler_writes);
            end
            3'd3: begin
                compare_count("acknowledges", 1, acks);
                compare_count("handler writes", 1, handler_writes);
            end
            3'd4: begin
                compare_count("acknowledges", 0, acks);
                compare_count("handler writes", 0, handler_writes);
            end
            3'd5: begin
                compare_count("acknowledges", 2, acks);
                compare_count("handler writes", 2, handler_writes);
            end
            default: begin
            end
        endcase
        $display("test %0d %s: %s with %0d errors", cur_test, test_name(cur_test),
                 (test_errors == 0) ? "passed" : "failed", test_errors);
        tests_run++;
        if (test_errors != 0) begin
            tests_failed++;
        end
        test_errors    = 0;
        acks           = 0;
        handler_writes = 0;
    endtask

    // outputs and stimulus are stable on the falling edge
    always @(negedge clk) begin
        if (!report_done) begin
            if (!reset) begin
                if (art_valid || irq_ack) begin
                    report_failure("art_valid or irq_ack high during reset");
                end
                // first write must use the key held through reset
                cur_key             = key_code;
                prev_key            = key_code;
                writes_since_change = 1;
            end else begin
                if (test_id != cur_test) begin
                    close_test();
                    cur_test = test_id;
                end
                // a write in the ack cycle belongs before the ack
                if (art_valid) begin
                    check_art_write();
                end
                if (irq_ack) begin
                    if (handler_pending) begin
                        report_failure("second acknowledge before the handler wrote 90");
                    end
                    handler_pending = 1'b1;
                    acks++;
                end
                if (key_code !== cur_key) begin
                    close_phase();
                    prev_key            = cur_key;
                    cur_key             = key_code;
                    writes_since_change = 0;
                    phase_matched       = 1'b0;
                    phase_active        = (cur_test == 3'd2);
                end
                if (run_done) begin
                    close_test();
                    $display("summary: %0d tests, %0d passed, %0d failed, %0d errors",
                             tests_run, tests_run - tests_failed, tests_failed, error_count);
                    report_done = 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* logic/rv_system.sv */
`timescale 1ns/1ns
`default_nettype none

module rv_system import rv_pkg::*; (
    input  wire        clk,
    input  wire        reset,
    input  wire xlen_t key_code,
    input  wire        irq,
    output logic       irq_ack,
    output logic       art_valid,
    output xlen_t      art_data
);

    // core to requesters
    logic     fetch_req;
    addr_t    pc;
    logic     instr_valid;
    instr_t   instr;
    logic     mem_req;
    logic     mem_write;
    addr_t    mem_addr;
    xlen_t    mem_wdata;
    logic     mem_done;
    xlen_t    mem_rdata;

    // requesters to interconnect
    apb_req_t fetch_bus_req;
    apb_rsp_t fetch_bus_rsp;
    logic     fetch_grant;
    apb_req_t lsu_bus_req;
    apb_rsp_t lsu_bus_rsp;
    logic     lsu_grant;

    // interconnect to targets
    apb_req_t ram_req;
    apb_rsp_t ram_rsp;
    apb_req_t io_req;
    apb_rsp_t io_rsp;

    rv_execute u_execute (
        .clk         (clk),
        .reset       (reset),
        .fetch_req   (fetch_req),
        .pc          (pc),
        .instr_valid (instr_valid),
        .instr       (instr),
        .mem_req     (mem_req),
        .mem_write   (mem_write),
        .mem_addr    (mem_addr),
        .mem_wdata   (mem_wdata),
        .mem_done    (mem_done),
        .mem_rdata   (mem_rdata),
        .irq         (irq),
        .irq_ack     (irq_ack)
    );

    rv_fetch u_fetch (
        .clk         (clk),
        .reset       (reset),
        .fetch_req   (fetch_req),
        .pc          (pc),
        .instr_valid (instr_valid),
        .instr       (instr),
        .bus_req     (fetch_bus_req),
        .bus_rsp     (fetch_bus_rsp),
        .grant       (fetch_grant)
    );

    rv_lsu u_lsu (
        .clk       (clk),
        .reset     (reset),
        .mem_req   (mem_req),
        .mem_write (mem_write),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_done  (mem_done),
        .mem_rdata (mem_rdata),
        .bus_req   (lsu_bus_req),
        .bus_rsp   (lsu_bus_rsp),
        .grant     (lsu_grant)
    );

    rv_bus_interconnect u_interconnect (
        .clk           (clk),
        .reset         (reset),
        .fetch_bus_req (fetch_bus_req),
        .fetch_bus_rsp (fetch_bus_rsp),
        .fetch_grant   (fetch_grant),
        .lsu_bus_req   (lsu_bus_req),
        .lsu_bus_rsp   (lsu_bus_rsp),
        .lsu_grant     (lsu_grant),
        .ram_req       (ram_req),
        .ram_rsp       (ram_rsp),
        .io_req        (io_req),
        .io_rsp        (io_rsp)
    );

    rv_ram u_ram (
        .clk (clk),
        .req (ram_req),
        .rsp (ram_rsp)
    );

    rv_io u_io (
        .clk       (clk),
        .reset     (reset),
        .req       (io_req),
        .rsp       (io_rsp),
        .key_code  (key_code),
        .art_valid (art_valid),
        .art_data  (art_data)
    );

endmodule

`default_nettype wire

/* logic/rv_io.sv */
`timescale 1ns/1ns
`default_nettype none
`include "rv_settings.svh"

module rv_io import rv_pkg::*; (
    input  wire           clk,
    input  wire           reset,
    input  wire apb_req_t req,
    output apb_rsp_t      rsp,
    input  wire xlen_t    key_code,
    output logic          art_valid,
    output xlen_t         art_data
);

    addr_t offset;
    logic  access;
    logic  art_wr;

    assign offset = req.paddr - `RV_IO_BASE;
    assign access = req.psel && req.penable;
    assign art_wr = access && req.pwrite && (offset == `RV_IO_ART_OFFSET);

    // key register is read only, other offsets read zero
    assign rsp.pready = access;
    assign rsp.prdata = (!req.pwrite && (offset == `RV_IO_KEY_OFFSET)) ? key_code : '0;

    // pulse one cycle after the write completes
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            art_valid <= 1'b0;
        end else begin
            art_valid <= art_wr;
        end
    end

    always_ff @(posedge clk) begin
        if (art_wr) begin
            art_data <= req.pwdata;
        end
    end

endmodule

`default_nettype wire

/* logic/rv_ram.sv */
`timescale 1ns/1ns
`default_nettype none
`include "rv_settings.svh"

module rv_ram import rv_pkg::*; (
    input  wire           clk,
    input  wire apb_req_t req,
    output apb_rsp_t      rsp
);

    localparam int ram_aw = $clog2(`RV_RAM_WORDS);

    xlen_t             mem [`RV_RAM_WORDS];
    logic [ram_aw-1:0] idx;
    logic              access;

    // program image, main loop and handler
    initial begin
        $readmemh("program.hex", mem);
    end

    // dword index from byte address
    assign idx    = req.paddr[ram_aw+2:3];
    assign access = req.psel && req.penable;

    // no wait states
    assign rsp.pready = access;
    assign rsp.prdata = mem[idx];

    always_ff @(posedge clk) begin
        if (access && req.pwrite) begin
            mem[idx] <= req.pwdata;
        end
    end

endmodule

`default_nettype wire

/* logic/rv_bus_interconnect.sv */
`timescale 1ns/1ns
`default_nettype none
`include "rv_settings.svh"

module rv_bus_interconnect import rv_pkg::*; (
    input  wire           clk,
    input  wire           reset,
    input  wire apb_req_t fetch_bus_req,
    output apb_rsp_t      fetch_bus_rsp,
    output logic          fetch_grant,
    input  wire apb_req_t lsu_bus_req,
    output apb_rsp_t      lsu_bus_rsp,
    output logic          lsu_grant,
    output apb_req_t      ram_req,
    input  wire apb_rsp_t ram_rsp,
    output apb_req_t      io_req,
    input  wire apb_rsp_t io_rsp
);

    logic     busy;
    logic     owner_lsu;
    logic     to_io;
    apb_req_t sel_req;
    apb_rsp_t tgt_rsp;

    // idle bus: lsu wins a tie; busy bus: owner keeps it
    assign lsu_grant   = busy ? owner_lsu : lsu_bus_req.psel;
    assign fetch_grant = busy ? !owner_lsu : (fetch_bus_req.psel && !lsu_bus_req.psel);

    always_comb begin
        if (lsu_grant) begin
            sel_req = lsu_bus_req;
        end else if (fetch_grant) begin
            sel_req = fetch_bus_req;
        end else begin
            sel_req = '0;
        end
    end

    // address decode
    assign to_io   = (sel_req.paddr >= `RV_IO_BASE);
    assign ram_req = to_io ? '0 : sel_req;
    assign io_req  = to_io ? sel_req : '0;
    assign tgt_rsp = to_io ? io_rsp : ram_rsp;

    // response only to the owner
    assign fetch_bus_rsp = fetch_grant ? tgt_rsp : '0;
    assign lsu_bus_rsp   = lsu_grant ? tgt_rsp : '0;

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            busy      <= 1'b0;
            owner_lsu <= 1'b0;
        end else if (!busy) begin
            if (lsu_grant || fetch_grant) begin
                busy      <= 1'b1;
                owner_lsu <= lsu_grant;
            end
        end else if (sel_req.penable && tgt_rsp.pready) begin
            // transfer done, release
            busy <= 1'b0;
        end
    end

endmodule

`default_nettype wire

/* logic/rv_lsu.sv */
`timescale 1ns/1ns
`default_nettype none

module rv_lsu import rv_pkg::*; (
    input  wire           clk,
    input  wire           reset,
    input  wire           mem_req,
    input  wire           mem_write,
    input  wire addr_t    mem_addr,
    input  wire xlen_t    mem_wdata,
    output logic          mem_done,
    output xlen_t         mem_rdata,
    output apb_req_t      bus_req,
    input  wire apb_rsp_t bus_rsp,
    input  wire           grant
);

    apb_phase_t phase;
    logic       done;
    logic       wr_q;
    addr_t      addr_q;
    xlen_t      wdata_q;

    // held from setup until pready
    always_comb begin
        bus_req         = '0;
        bus_req.psel    = (phase != apb_idle);
        bus_req.penable = (phase == apb_access);
        bus_req.pwrite  = wr_q;
        bus_req.paddr   = addr_q;
        bus_req.pwdata  = wdata_q;
    end

    assign done = (phase == apb_access) && bus_rsp.pready;

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            phase    <= apb_idle;
            mem_done <= 1'b0;
        end else begin
            mem_done <= done;
            case (phase)
                apb_idle:   if (mem_req) phase <= apb_setup;
                apb_setup:  if (grant) phase <= apb_access;
                apb_access: if (bus_rsp.pready) phase <= apb_idle;
                default:    phase <= apb_idle;
            endcase
        end
    end

    // latch the request, capture read data
    always_ff @(posedge clk) begin
        if (mem_req && (phase == apb_idle)) begin
            wr_q    <= mem_write;
            addr_q  <= mem_addr;
            wdata_q <= mem_wdata;
        end
        if (done) begin
            mem_rdata <= bus_rsp.prdata;
        end
    end

endmodule

`default_nettype wire

/* logic/rv_fetch.sv */
`timescale 1ns/1ns
`default_nettype none

module rv_fetch import rv_pkg::*; (
    input  wire           clk,
    input  wire           reset,
    input  wire           fetch_req,
    input  wire addr_t    pc,
    output logic          instr_valid,
    output instr_t        instr,
    output apb_req_t      bus_req,
    input  wire apb_rsp_t bus_rsp,
    input  wire           grant
);

    apb_phase_t phase;
    logic       done;

    // pc stays stable while the core waits, so it drives paddr directly
    always_comb begin
        bus_req         = '0;
        bus_req.psel    = (phase != apb_idle);
        bus_req.penable = (phase == apb_access);
        bus_req.pwrite  = 1'b0;
        bus_req.paddr   = {pc[31:3], 3'b000};
    end

    assign done = (phase == apb_access) && bus_rsp.pready;

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            phase       <= apb_idle;
            instr_valid <= 1'b0;
        end else begin
            instr_valid <= done;
            case (phase)
                apb_idle:   if (fetch_req) phase <= apb_setup;
                // wait here until the interconnect grants
                apb_setup:  if (grant) phase <= apb_access;
                apb_access: if (bus_rsp.pready) phase <= apb_idle;
                default:    phase <= apb_idle;
            endcase
        end
    end

    // pick the 32-bit half of the dword
    always_ff @(posedge clk) begin
        if (done) begin
            instr <= pc[2] ? bus_rsp.prdata[63:32] : bus_rsp.prdata[31:0];
        end
    end

endmodule

`default_nettype wire

/* logic/rv_execute.sv */
`timescale 1ns/1ns
`default_nettype none
`include "rv_settings.svh"

module rv_execute import rv_pkg::*; (
    input  wire         clk,
    input  wire         reset,
    output logic        fetch_req,
    output addr_t       pc,
    input  wire         instr_valid,
    input  wire instr_t instr,
    output logic        mem_req,
    output logic        mem_write,
    output addr_t       mem_addr,
    output xlen_t       mem_wdata,
    input  wire         mem_done,
    input  wire xlen_t  mem_rdata,
    input  wire         irq,
    output logic        irq_ack
);

    // opcodes of the supported subset
    localparam logic [6:0] op_lui   = 7'b0110111;
    localparam logic [6:0] op_imm   = 7'b0010011;
    localparam logic [6:0] op_load  = 7'b0000011;
    localparam logic [6:0] op_store = 7'b0100011;
    localparam logic [6:0] op_jal   = 7'b1101111;
    localparam logic [2:0] f3_addi  = 3'b000;
    localparam logic [2:0] f3_dword = 3'b011;
    localparam instr_t     mret_word = 32'h3020_0073;

    exec_state_t state;
    instr_t      ir;
    addr_t       mepc;
    logic        in_handler;
    xlen_t       regs [32];

    reg_idx_t rd;
    reg_idx_t rs1;
    reg_idx_t rs2;
    xlen_t    rs1_val;
    xlen_t    rs2_val;
    xlen_t    imm_i;
    xlen_t    imm_s;
    xlen_t    imm_u;
    xlen_t    imm_j;
    xlen_t    ea_load;
    xlen_t    ea_store;
    addr_t    pc_plus4;
    addr_t    pc_jal;
    logic     is_lui;
    logic     is_addi;
    logic     is_ld;
    logic     is_sd;
    logic     is_jal;
    logic     is_mret;
    logic     rf_we;
    xlen_t    rf_wd;

    assign rd  = ir[11:7];
    assign rs1 = ir[19:15];
    assign rs2 = ir[24:20];

    // x0 is hardwired to zero
    assign rs1_val = (rs1 == '0) ? '0 : regs[rs1];
    assign rs2_val = (rs2 == '0) ? '0 : regs[rs2];

    // sign-extended immediates
    assign imm_i = {{52{ir[31]}}, ir[31:20]};
    assign imm_s = {{52{ir[31]}}, ir[31:25], ir[11:7]};
    assign imm_u = {{32{ir[31]}}, ir[31:12], 12'b0};
    assign imm_j = {{43{ir[31]}}, ir[31], ir[19:12], ir[20], ir[30:21], 1'b0};

    assign ea_load  = rs1_val + imm_i;
    assign ea_store = rs1_val + imm_s;
    assign pc_plus4 = pc + 32'd4;
    assign pc_jal   = pc + imm_j[31:0];

    // decode
    assign is_lui  = (ir[6:0] == op_lui);
    assign is_addi = (ir[6:0] == op_imm) && (ir[14:12] == f3_addi);
    assign is_ld   = (ir[6:0] == op_load) && (ir[14:12] == f3_dword);
    assign is_sd   = (ir[6:0] == op_store) && (ir[14:12] == f3_dword);
    assign is_jal  = (ir[6:0] == op_jal);
    assign is_mret = (ir == mret_word);

    // writeback select, loads land when the lsu is done
    always_comb begin
        rf_we = 1'b0;
        rf_wd = '0;
        if (state == exec_wait_mem) begin
            rf_we = mem_done && !mem_write;
            rf_wd = mem_rdata;
        end else if (state == exec_execute) begin
            rf_we = is_lui || is_addi || is_jal;
            if (is_lui) begin
                rf_wd = imm_u;
            end else if (is_addi) begin
                rf_wd = ea_load;
            end else begin
                // link value
                rf_wd = {32'b0, pc_plus4};
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rf_we && (rd != '0)) begin
            regs[rd] <= rf_wd;
        end
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            state      <= exec_fetch;
            pc         <= `RV_RESET_PC;
            mepc       <= `RV_RESET_PC;
            in_handler <= 1'b0;
            fetch_req  <= 1'b0;
            mem_req    <= 1'b0;
            irq_ack    <= 1'b0;
        end else begin
            fetch_req <= 1'b0;
            mem_req   <= 1'b0;
            irq_ack   <= 1'b0;
            case (state)
                exec_fetch: begin
                    // instruction boundary, irq masked while in handler
                    if (irq && !in_handler) begin
                        mepc       <= pc;
                        pc         <= `RV_TRAP_VECTOR;
                        in_handler <= 1'b1;
                        irq_ack    <= 1'b1;
                    end else begin
                        fetch_req <= 1'b1;
                        state     <= exec_wait_fetch;
                    end
                end
                exec_wait_fetch: begin
                    if (instr_valid) begin
                        state <= exec_execute;
                    end
                end
                exec_execute: begin
                    pc    <= pc_plus4;
                    state <= exec_fetch;
                    if (is_ld || is_sd) begin
                        mem_req <= 1'b1;
                        state   <= exec_wait_mem;
                    end else if (is_jal) begin
                        pc <= pc_jal;
                    end else if (is_mret) begin
                        // back to the interrupted instruction
                        pc         <= mepc;
                        in_handler <= 1'b0;
                    end
                end
                exec_wait_mem: begin
                    if (mem_done) begin
                        state <= exec_fetch;
                    end
                end
                default: state <= exec_fetch;
            endcase
        end
    end

    // instruction and memory request payload
    always_ff @(posedge clk) begin
        if ((state == exec_wait_fetch) && instr_valid) begin
            ir <= instr;
        end
        if ((state == exec_execute) && (is_ld || is_sd)) begin
            mem_write <= is_sd;
            mem_addr  <= is_sd ? ea_store[31:0] : ea_load[31:0];
            mem_wdata <= rs2_val;
        end
    end

endmodule

`default_nettype wire

/* logic/rv_pkg.sv */
`default_nettype none

package rv_pkg;

    // data, byte address, instruction, register index
    typedef logic [63:0] xlen_t;
    typedef logic [31:0] addr_t;
    typedef logic [31:0] instr_t;
    typedef logic [4:0]  reg_idx_t;

    // requester side of apb
    typedef struct packed {
        logic  psel;
        logic  penable;
        logic  pwrite;
        addr_t paddr;
        xlen_t pwdata;
    } apb_req_t;

    // target side of apb, no pslverr here
    typedef struct packed {
        xlen_t prdata;
        logic  pready;
    } apb_rsp_t;

    // core phases, one instruction in flight
    typedef enum logic [1:0] {
        exec_fetch,
        exec_wait_fetch,
        exec_execute,
        exec_wait_mem
    } exec_state_t;

    // apb requester phases
    typedef enum logic [1:0] {
        apb_idle,
        apb_setup,
        apb_access
    } apb_phase_t;

endpackage

`default_nettype wire

/* logic/rv_settings.svh */
`ifndef RV_SETTINGS_SVH
`define RV_SETTINGS_SVH

// first instruction of the main loop
`define RV_RESET_PC 32'h0000_0100

// interrupt handler entry
`define RV_TRAP_VECTOR 32'h0000_0000

// io window, everything below goes to ram
`define RV_IO_BASE 32'h0000_2000
`define RV_IO_KEY_OFFSET 32'h0000_0000
`define RV_IO_ART_OFFSET 32'h0000_0008

// ram depth in 64-bit words
`define RV_RAM_WORDS 512

`endif
